// ==== sim.f ====
+incdir+rtl
rtl/cab_pkg.sv
rtl/ps2_keyboard.sv
rtl/control_mapper.sv
rtl/video_out.sv
rtl/sigma_delta_dac.sv
rtl/dominos_cab.sv
tb/dominos_cab_assertions.sv
tb/dominos_cab_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cabinet adapter simulation with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module dominos_cab_tb \
	-Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vdominos_cab_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Errors found" "$LOG"; then
	exit 1
fi
exit 0

// ==== tb/dominos_cab_tb.sv ====
// Cabinet adapter testbench
`default_nettype none
`include "cab_settings.svh"

module dominos_cab_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import cab_pkg::*;

	localparam int PS2_HALF = 500;  // 10 kHz PS/2 clock.
	localparam int WAIT_MAX = 200;

	logic                    clk_24 = 1'b0;
	logic                    rst;
	logic                    ps2_kbd_clk;
	logic                    ps2_kbd_data;
	joy_t                    joy0;
	joy_t                    joy1;
	logic [31:0]             status;
	logic [1:0]              buttons;
	core_video_t             video;
	logic [`CAB_AUDIO_W-1:0] audio;
	game_ctrl_t              ctrl;
	logic [`CAB_VGA_W-1:0]   vga_r;
	logic [`CAB_VGA_W-1:0]   vga_g;
	logic [`CAB_VGA_W-1:0]   vga_b;
	logic                    vga_hs;
	logic                    vga_vs;
	logic                    audio_l;
	logic                    audio_r;
	logic [31:0]             lfsr;
	int                      errors;
	int                      test_errors;
	int                      tests;

	dominos_cab dominos_cab_inst (.*);

	always #50 clk_24 = ~clk_24;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1.
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_24);
	endtask

	task automatic next_cycle();
		@(posedge clk_24);
		@(negedge clk_24); // outputs settle here.
	endtask

	// start, data lsb first, odd parity, stop
	task automatic ps2_send(input logic [7:0] code, input logic bad_parity = 1'b0);
		logic [10:0] bits;
		bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk_24);
			ps2_kbd_data <= bits[i];
			idle_cycles(PS2_HALF / 2);
			ps2_kbd_clk <= 1'b0;
			idle_cycles(PS2_HALF);
			ps2_kbd_clk <= 1'b1;
			idle_cycles(PS2_HALF / 2);
		end
		ps2_kbd_data <= 1'b1;
	endtask

	task automatic check_ctrl(input string name, input game_ctrl_t exp);
		if (ctrl !== exp) begin
			$display("ERROR %s: ctrl expected %h, actual %h", name, exp, ctrl);
			test_errors++;
		end
	endtask

	task automatic check_vga(input string name, input logic [`CAB_VGA_W-1:0] grey,
			input logic hs, input logic vs);
		if (vga_r !== grey || vga_g !== grey || vga_b !== grey || vga_hs !== hs
				|| vga_vs !== vs) begin
			$display("ERROR %s: expected %h hs %b vs %b, actual rgb %h %h %h hs %b vs %b",
				name, grey, hs, vs, vga_r, vga_g, vga_b, vga_hs, vga_vs);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("ERROR %s: ones expected %0d, actual %0d", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic wait_ctrl(input string name, input game_ctrl_t exp);
		int n;
		n = 0;
		@(negedge clk_24);
		while (ctrl !== exp && n < WAIT_MAX) begin
			@(negedge clk_24);
			n++;
		end
		if (n == WAIT_MAX)
			$display("%s: ctrl did not reach the expected value in %0d cycles", name, WAIT_MAX);
		check_ctrl(name, exp);
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
			$display("test %s: passed", name);
		else
			$display("test %s: %0d errors", name, test_errors);
		errors += test_errors;
		test_errors = 0;
		tests++;
	endtask

	// the control a single joystick bit should pull low
	function automatic game_ctrl_t joy_expect(input int player, input int b);
		game_ctrl_t e;
		e = '1;
		if (player == 0) begin
			case (b)
				0:       e.right1_n = 1'b0;
				1:       e.left1_n  = 1'b0;
				2:       e.down1_n  = 1'b0;
				3:       e.up1_n    = 1'b0;
				default: e.start1_n = 1'b0;
			endcase
		end else begin
			case (b)
				0:       e.right2_n = 1'b0;
				1:       e.left2_n  = 1'b0;
				2:       e.down2_n  = 1'b0;
				3:       e.up2_n    = 1'b0;
				default: e.start2_n = 1'b0;
			endcase
		end
		return e;
	endfunction

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	task automatic test_reset();
		next_cycle();
		check_ctrl("reset", '1);
		check_vga("reset", '0, 1'b0, 1'b0);
		if (audio_l !== 1'b0) begin
			$display("ERROR reset: audio_l expected 0, actual %b", audio_l);
			test_errors++;
		end
		finish_test("reset");
	endtask

	task automatic test_keyboard();
		game_ctrl_t exp;
		exp = '1;
		exp.up1_n = 1'b0;
		ps2_send(`CAB_SC_EXT);
		ps2_send(`CAB_SC_UP);
		wait_ctrl("keyboard up make", exp);
		ps2_send(`CAB_SC_EXT);
		ps2_send(`CAB_SC_BREAK);
		ps2_send(`CAB_SC_UP);
		wait_ctrl("keyboard up break", '1);
		exp = '1;
		exp.coin1_n = 1'b0;
		exp.coin2_n = 1'b0;
		ps2_send(`CAB_SC_COIN);
		wait_ctrl("keyboard coin make", exp);
		ps2_send(`CAB_SC_BREAK);
		ps2_send(`CAB_SC_COIN);
		wait_ctrl("keyboard coin break", '1);
		ps2_send(`CAB_SC_COIN, 1'b1);
		idle_cycles(20);
		@(negedge clk_24);
		check_ctrl("keyboard bad parity", '1);
		finish_test("keyboard");
	endtask

	task automatic test_joystick();
		game_ctrl_t exp;
		for (int p = 0; p < 2; p++) begin
			for (int b = 0; b < 5; b++) begin
				@(posedge clk_24);
				if (p == 0)
					joy0 <= joy_t'(8'(1) << b);
				else
					joy1 <= joy_t'(8'(1) << b);
				next_cycle();
				check_ctrl($sformatf("joy%0d bit %0d", p, b), joy_expect(p, b));
				@(posedge clk_24);
				joy0 <= '0;
				joy1 <= '0;
			end
		end
		// up held on key and stick, each source let go first in turn
		exp = joy_expect(0, 3);
		ps2_send(`CAB_SC_EXT);
		ps2_send(`CAB_SC_UP);
		wait_ctrl("merge key held", exp);
		@(posedge clk_24);
		joy0 <= joy_t'(8'h08);
		next_cycle();
		check_ctrl("merge both held", exp);
		@(posedge clk_24);
		joy0 <= '0;
		next_cycle();
		check_ctrl("merge stick released", exp);
		@(posedge clk_24);
		joy0 <= joy_t'(8'h08);
		ps2_send(`CAB_SC_EXT);
		ps2_send(`CAB_SC_BREAK);
		ps2_send(`CAB_SC_UP);
		@(negedge clk_24);
		check_ctrl("merge key released", exp);
		@(posedge clk_24);
		joy0 <= '0;
		next_cycle();
		check_ctrl("merge both released", '1);
		finish_test("joystick");
	endtask

	task automatic test_status();
		game_ctrl_t exp;
		exp = '1;
		exp.test_n = 1'b0;
		@(posedge clk_24);
		status <= 32'h0000_0002;
		next_cycle();
		check_ctrl("status self test", exp);
		exp = '1;
		exp.reset_n = 1'b0;
		for (int i = 0; i < 3; i++) begin
			@(posedge clk_24);
			status  <= (i == 0) ? 32'h0000_0001 : (i == 1) ? 32'h0000_0040 : 32'h0;
			buttons <= (i == 2) ? 2'b10 : 2'b00;
			next_cycle();
			check_ctrl($sformatf("reset request %0d", i), exp);
			@(posedge clk_24);
			status  <= '0;
			buttons <= '0;
			next_cycle();
			check_ctrl($sformatf("reset request %0d cleared", i), '1);
		end
		finish_test("status");
	endtask

	task automatic test_video();
		logic [31:0]           r;
		core_video_t           v;
		logic [`CAB_VGA_W-1:0] grey;
		for (int i = 0; i < 32; i++) begin
			take_bits(12, r);
			v = core_video_t'(r[11:0]);
			grey = (v.hb || v.vb) ? '0 : v.lum[7:2];
			@(posedge clk_24);
			video <= v;
			next_cycle();
			check_vga($sformatf("video %0d", i), grey, v.hs, v.vs);
		end
		@(posedge clk_24);
		video <= '0;
		finish_test("video");
	endtask

	task automatic test_audio();
		logic [31:0] r;
		int          ones;
		logic        split;
		for (int i = 0; i < 4; i++) begin
			take_bits(`CAB_AUDIO_W, r);
			@(posedge clk_24);
			audio <= r[`CAB_AUDIO_W-1:0];
			idle_cycles(128); // let the residue settle.
			ones = 0;
			split = 1'b0;
			for (int c = 0; c < 128; c++) begin
				@(negedge clk_24);
				if (audio_l) ones++;
				if (audio_r !== audio_l) split = 1'b1;
			end
			if (split) begin
				$display("audio sample %0d: audio_r did not follow audio_l", i);
				test_errors++;
			end
			check_count($sformatf("audio sample %0d", i), int'(r[`CAB_AUDIO_W-1:0]), ones);
		end
		finish_test("audio");
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		rst          = 1'b1;
		ps2_kbd_clk  = 1'b1;
		ps2_kbd_data = 1'b1;
		joy0         = '0;
		joy1         = '0;
		status       = '0;
		buttons      = '0;
		video        = '0;
		audio        = '0;
		lfsr         = 32'h3fd97fd9;
		errors       = 0;
		test_errors  = 0;
		tests        = 0;
		repeat (8) @(posedge clk_24);
		rst <= 1'b0;
		test_reset();
		test_keyboard();
		test_joystick();
		test_status();
		test_video();
		test_audio();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/dominos_cab_assertions.sv ====
// Cabinet adapter assertions
`default_nettype none
`include "cab_settings.svh"

module dominos_cab_assertions (
	input wire                        clk_24,
	input wire                        rst,
	input wire cab_pkg::core_video_t  video,
	input wire cab_pkg::game_ctrl_t   ctrl,
	input wire [`CAB_VGA_W-1:0]       vga_r,
	input wire [`CAB_VGA_W-1:0]       vga_g,
	input wire [`CAB_VGA_W-1:0]       vga_b,
	input wire                        audio_l,
	input wire                        audio_r
);
	timeunit 1ns;
	timeprecision 100ps;

	// core stays in reset one cycle behind the system reset
	core_reset_follows_rst: assert property (@(posedge clk_24) $past(rst) |-> !ctrl.reset_n)
		else $error("ctrl reset_n high one cycle after rst");

	// ----------------------------------------------------------------------
	// video and audio outputs
	// ----------------------------------------------------------------------
	blank_gives_black: assert property (@(posedge clk_24) disable iff (rst)
		(video.hb || video.vb) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else $error("colour not 0 one cycle after blanking");

	audio_mono: assert property (@(posedge clk_24) audio_r == audio_l)
		else $error("audio_r differs from audio_l");

endmodule

bind dominos_cab dominos_cab_assertions dominos_cab_assertions_inst (
	.clk_24  (clk_24),
	.rst     (rst),
	.video   (video),
	.ctrl    (ctrl),
	.vga_r   (vga_r),
	.vga_g   (vga_g),
	.vga_b   (vga_b),
	.audio_l (audio_l),
	.audio_r (audio_r)
);

`default_nettype wire

// ==== rtl/dominos_cab.sv ====
// Dominos cabinet adapter
`default_nettype none
`include "cab_settings.svh"

module dominos_cab (
	input  wire                        clk_24,
	input  wire                        rst,
	input  wire                        ps2_kbd_clk,
	input  wire                        ps2_kbd_data,
	input  wire cab_pkg::joy_t         joy0,
	input  wire cab_pkg::joy_t         joy1,
	input  wire [31:0]                 status,
	input  wire [1:0]                  buttons,
	input  wire cab_pkg::core_video_t  video,
	input  wire [`CAB_AUDIO_W-1:0]     audio,
	output wire cab_pkg::game_ctrl_t   ctrl,
	output wire [`CAB_VGA_W-1:0]       vga_r,
	output wire [`CAB_VGA_W-1:0]       vga_g,
	output wire [`CAB_VGA_W-1:0]       vga_b,
	output wire                        vga_hs,
	output wire                        vga_vs,
	output wire                        audio_l,
	output wire                        audio_r
);
	import cab_pkg::*;

	kbjoy_t kbjoy;

	// ----------------------------------------------------------------------
	// input side
	// ----------------------------------------------------------------------
	ps2_keyboard ps2_keyboard_inst (
		.clk_24       (clk_24),
		.rst          (rst),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.kbjoy        (kbjoy)
	);

	control_mapper control_mapper_inst (
		.clk_24  (clk_24),
		.rst     (rst),
		.kbjoy   (kbjoy),
		.joy0    (joy0),
		.joy1    (joy1),
		.status  (status),
		.buttons (buttons),
		.ctrl    (ctrl)
	);

	// ----------------------------------------------------------------------
	// output side
	// ----------------------------------------------------------------------
	video_out video_out_inst (
		.clk_24 (clk_24),
		.rst    (rst),
		.video  (video),
		.vga_r  (vga_r),
		.vga_g  (vga_g),
		.vga_b  (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs)
	);

	sigma_delta_dac sigma_delta_dac_inst (
		.clk_24 (clk_24),
		.rst    (rst),
		.sample (audio),
		.dout   (audio_l)
	);

	assign audio_r = audio_l; // mono core, both channels.

endmodule

`default_nettype wire

// ==== rtl/sigma_delta_dac.sv ====
// Sigma-delta audio DAC
`default_nettype none
`include "cab_settings.svh"

module sigma_delta_dac (
	input  wire                    clk_24,
	input  wire                    rst,
	input  wire [`CAB_AUDIO_W-1:0] sample,
	output logic                   dout
);

	// residue in the low bits, carry on top
	logic [`CAB_AUDIO_W:0] acc;

	// ----------------------------------------------------------------------
	// first order modulator
	// ----------------------------------------------------------------------
	// The residue wraps modulo 2**W, so over 2**W cycles with a fixed sample
	// the carry fires exactly sample times.
	always_ff @(posedge clk_24) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[`CAB_AUDIO_W-1:0]} + {1'b0, sample}; // drop old carry.
	end

	assign dout = acc[`CAB_AUDIO_W]; // registered carry is the pulse stream.

endmodule

`default_nettype wire

// ==== rtl/video_out.sv ====
// Grey VGA output stage
`default_nettype none
`include "cab_settings.svh"

module video_out (
	input  wire                      clk_24,
	input  wire                      rst,
	input  wire cab_pkg::core_video_t video,
	output logic [`CAB_VGA_W-1:0]    vga_r,
	output logic [`CAB_VGA_W-1:0]    vga_g,
	output logic [`CAB_VGA_W-1:0]    vga_b,
	output logic                     vga_hs,
	output logic                     vga_vs
);

	logic                  blank;
	logic [`CAB_VGA_W-1:0] grey;
	logic [`CAB_VGA_W-1:0] grey_q;

	assign blank = video.hb | video.vb;
	assign grey  = blank ? '0 : video.lum[7 -: `CAB_VGA_W]; // top bits of lum.

	// ----------------------------------------------------------------------
	// one register stage keeps colour and syncs aligned
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_24) begin
		if (rst) begin
			grey_q <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			grey_q <= grey;
			vga_hs <= video.hs;
			vga_vs <= video.vs;
		end
	end

	// monochrome, same level on all three guns
	assign vga_r = grey_q;
	assign vga_g = grey_q;
	assign vga_b = grey_q;

endmodule

`default_nettype wire

// ==== rtl/control_mapper.sv ====
// Game control mapper
`default_nettype none

module control_mapper (
	input  wire                 clk_24,
	input  wire                 rst,
	input  wire cab_pkg::kbjoy_t kbjoy,
	input  wire cab_pkg::joy_t  joy0,
	input  wire cab_pkg::joy_t  joy1,
	input  wire [31:0]          status,
	input  wire [1:0]           buttons,
	output cab_pkg::game_ctrl_t ctrl
);
	import cab_pkg::*;

	game_ctrl_t ctrl_d;

	// ----------------------------------------------------------------------
	// keyboard or joystick, inverted for the core
	// ----------------------------------------------------------------------
	always_comb begin
		ctrl_d.up1_n    = ~(kbjoy.up1 | joy0.up);
		ctrl_d.down1_n  = ~(kbjoy.down1 | joy0.down);
		ctrl_d.left1_n  = ~(kbjoy.left1 | joy0.left);
		ctrl_d.right1_n = ~(kbjoy.right1 | joy0.right);
		ctrl_d.up2_n    = ~(kbjoy.up2 | joy1.up);
		ctrl_d.down2_n  = ~(kbjoy.down2 | joy1.down);
		ctrl_d.left2_n  = ~(kbjoy.left2 | joy1.left);
		ctrl_d.right2_n = ~(kbjoy.right2 | joy1.right);
		ctrl_d.start1_n = ~(kbjoy.start1 | joy0.start);
		ctrl_d.start2_n = ~(kbjoy.start2 | joy1.start);
		ctrl_d.coin1_n  = ~kbjoy.coin;                // one coin key feeds both slots.
		ctrl_d.coin2_n  = ~kbjoy.coin;
		ctrl_d.test_n   = ~status[1];                 // self test from the menu.
		ctrl_d.reset_n  = ~(status[0] | status[6] | buttons[1]);
	end

	always_ff @(posedge clk_24) begin
		if (rst) begin
			ctrl         <= '1;
			ctrl.reset_n <= 1'b0; // core held in reset with the system.
		end else begin
			ctrl <= ctrl_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ps2_keyboard.sv ====
// PS/2 keyboard joystick
`default_nettype none
`include "cab_settings.svh"

module ps2_keyboard (
	input  wire             clk_24,
	input  wire             rst,
	input  wire             ps2_kbd_clk,
	input  wire             ps2_kbd_data,
	output cab_pkg::kbjoy_t kbjoy
);
	import cab_pkg::*;

	localparam int IDLE_W = 13;

	logic [1:0]        clk_sync;
	logic [1:0]        dat_sync;
	logic              clk_prev;
	logic              fall;
	logic [10:0]       frame;
	logic [3:0]        bit_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	logic              frame_full;
	logic              frame_ok;
	logic [7:0]        code;
	logic              ext;
	logic              brk;
	logic              key_hit;
	logic [3:0]        key_idx;
	logic [11:0]       held;

	// ----------------------------------------------------------------------
	// line synchronisers and falling edge detect
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_24) begin
		if (rst) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_kbd_clk};
			dat_sync <= {dat_sync[0], ps2_kbd_data};
			clk_prev <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// ----------------------------------------------------------------------
	// frame shifter, lsb first, with idle timeout
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_24) begin
		if (fall)
			frame <= {dat_sync[1], frame[10:1]}; // start bit ends in frame[0].
	end

	always_ff @(posedge clk_24) begin
		if (rst) begin
			bit_cnt    <= '0;
			idle_cnt   <= '0;
			frame_full <= 1'b0;
		end else begin
			frame_full <= 1'b0;
			if (fall) begin
				idle_cnt <= '0;
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0;
					frame_full <= 1'b1; // stop bit in.
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (!clk_sync[1]) begin
				idle_cnt <= '0;
			end else if (idle_cnt[IDLE_W-1]) begin
				bit_cnt <= '0; // lost sync, start over.
			end else begin
				idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

	// odd parity over data and parity bit
	assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);
	assign code     = frame[8:1];

	// ----------------------------------------------------------------------
	// scancode lookup
	// ----------------------------------------------------------------------
	always_comb begin
		key_hit = 1'b1;
		key_idx = '0;
		if (ext) begin
			case (code)
				`CAB_SC_RIGHT: key_idx = `CAB_KB_RIGHT1;
				`CAB_SC_LEFT:  key_idx = `CAB_KB_LEFT1;
				`CAB_SC_DOWN:  key_idx = `CAB_KB_DOWN1;
				`CAB_SC_UP:    key_idx = `CAB_KB_UP1;
				default:       key_hit = 1'b0;
			endcase
		end else begin
			case (code)
				`CAB_SC_START1: key_idx = `CAB_KB_START1;
				`CAB_SC_START2: key_idx = `CAB_KB_START2;
				`CAB_SC_COIN:   key_idx = `CAB_KB_COIN;
				`CAB_SC_D:      key_idx = `CAB_KB_RIGHT2;
				`CAB_SC_A:      key_idx = `CAB_KB_LEFT2;
				`CAB_SC_S:      key_idx = `CAB_KB_DOWN2;
				`CAB_SC_W:      key_idx = `CAB_KB_UP2;
				default:        key_hit = 1'b0;
			endcase
		end
	end

	// prefix state and held keys
	always_ff @(posedge clk_24) begin
		if (rst) begin
			ext  <= 1'b0;
			brk  <= 1'b0;
			held <= '0;
		end else if (frame_full && frame_ok) begin
			if (code == `CAB_SC_EXT) begin
				ext <= 1'b1;
			end else if (code == `CAB_SC_BREAK) begin
				brk <= 1'b1;
			end else begin
				if (key_hit)
					held[key_idx] <= ~brk; // make sets, break clears.
				ext <= 1'b0;
				brk <= 1'b0;
			end
		end
	end

	assign kbjoy = kbjoy_t'(held);

endmodule

`default_nettype wire

// ==== rtl/cab_pkg.sv ====
// Cabinet adapter types
`default_nettype none

package cab_pkg;

	// ----------------------------------------------------------------------
	// joystick word from the IO controller, active high
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic [2:0] spare;
		logic       start;
		logic       up;
		logic       down;
		logic       left;
		logic       right;   // bit 0.
	} joy_t;

	// keyboard joystick word, 1 while the key is held
	typedef struct packed {
		logic up2;
		logic down2;
		logic left2;
		logic right2;    // bit 8.
		logic coin;
		logic start2;
		logic start1;
		logic spare;     // bit 4.
		logic up1;
		logic down1;
		logic left1;
		logic right1;    // bit 0.
	} kbjoy_t;

	// ----------------------------------------------------------------------
	// game core inputs, all active low
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic up1_n;
		logic down1_n;
		logic left1_n;
		logic right1_n;
		logic up2_n;
		logic down2_n;
		logic left2_n;
		logic right2_n;
		logic start1_n;
		logic start2_n;
		logic coin1_n;
		logic coin2_n;
		logic test_n;
		logic reset_n;   // bit 0.
	} game_ctrl_t;

	// raw video from the core
	typedef struct packed {
		logic [7:0] lum;
		logic       hs;
		logic       vs;
		logic       hb;
		logic       vb;
	} core_video_t;

endpackage

`default_nettype wire

// ==== rtl/cab_settings.svh ====
// Cabinet adapter settings
`ifndef CAB_SETTINGS_SVH
`define CAB_SETTINGS_SVH

// ----------------------------------------------------------------------
// channel widths
// ----------------------------------------------------------------------
`define CAB_AUDIO_W   7       // core audio sample.
`define CAB_VGA_W     6       // one VGA colour channel.

// ----------------------------------------------------------------------
// PS/2 set 2 scancodes
// ----------------------------------------------------------------------
`define CAB_SC_RIGHT  8'h74   // arrows come after E0.
`define CAB_SC_LEFT   8'h6B
`define CAB_SC_DOWN   8'h72
`define CAB_SC_UP     8'h75
`define CAB_SC_START1 8'h16   // key 1.
`define CAB_SC_START2 8'h1E   // key 2.
`define CAB_SC_COIN   8'h2E   // key 5.
`define CAB_SC_D      8'h23
`define CAB_SC_A      8'h1C
`define CAB_SC_S      8'h1B
`define CAB_SC_W      8'h1D
`define CAB_SC_EXT    8'hE0
`define CAB_SC_BREAK  8'hF0

// bit positions in the key joystick word
`define CAB_KB_RIGHT1 0
`define CAB_KB_LEFT1  1
`define CAB_KB_DOWN1  2
`define CAB_KB_UP1    3
`define CAB_KB_START1 5
`define CAB_KB_START2 6
`define CAB_KB_COIN   7
`define CAB_KB_RIGHT2 8
`define CAB_KB_LEFT2  9
`define CAB_KB_DOWN2  10
`define CAB_KB_UP2    11

`endif
